// File: include/tawas_cfg.svh
////////////////////////////////////////
// Slice and register counts must stay powers of two
// Instruction addresses count 32-bit words, not bytes
////////////////////////////////////////

`ifndef TAWAS_CFG_SVH
`define TAWAS_CFG_SVH

// Hardware threads that take turns in the pipeline
`define TAWAS_SLICES 4

// Registers in each slice's bank
`define TAWAS_REGS 8

// Width of an instruction word address
`define TAWAS_IADDR_W 24

// Distance between start addresses, slice s starts at s times this value
`define TAWAS_SLICE_BASE 64

`endif

// File: source/tawas_pkg.sv
////////////////////////////////////////
// ST writes rb to ra plus the sign-extended immediate
// BZ tests ra, branch targets are zero-extended
////////////////////////////////////////

`include "tawas_cfg.svh"

package tawas_pkg;

  typedef logic [31:0]                       word_t;
  typedef logic [`TAWAS_IADDR_W-1:0]         iaddr_t;
  typedef logic [$clog2(`TAWAS_SLICES)-1:0]  slice_t;
  typedef logic [$clog2(`TAWAS_REGS)-1:0]    reg_sel_t;
  typedef logic [3:0]                        opcode_t;
  typedef logic [15:0]                       imm_t;

  localparam opcode_t OP_NOP = 4'd0;
  localparam opcode_t OP_LDI = 4'd1;
  localparam opcode_t OP_ADD = 4'd2;
  localparam opcode_t OP_SUB = 4'd3;
  localparam opcode_t OP_AND = 4'd4;
  localparam opcode_t OP_XOR = 4'd5;
  localparam opcode_t OP_LD  = 4'd6;
  localparam opcode_t OP_ST  = 4'd7;
  localparam opcode_t OP_BZ  = 4'd8;
  localparam opcode_t OP_JMP = 4'd9;

  // Instruction word layout, bits 18 to 16 are unused
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RC_MSB  = 27;
  localparam int RC_LSB  = 25;
  localparam int RA_MSB  = 24;
  localparam int RA_LSB  = 22;
  localparam int RB_MSB  = 21;
  localparam int RB_LSB  = 19;
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;

endpackage

// File: source/tawas_rf_if.sv
////////////////////////////////////////
// One instance per slice, reads are combinational
////////////////////////////////////////

`timescale 1ns/10ps

interface tawas_rf_if;
  import tawas_pkg::*;

  // Read side, selects from exec and data back from the bank
  reg_sel_t ra_sel;
  reg_sel_t rb_sel;
  word_t    ra;
  word_t    rb;

  // Write side, owned by writeback
  logic     we;
  reg_sel_t wsel;
  word_t    wdata;

  modport bank (
    input  ra_sel, rb_sel, we, wsel, wdata,
    output ra, rb
  );

  modport reader (output ra_sel, rb_sel, input ra, rb);

  modport writer (output we, wsel, wdata);

endinterface

// File: source/tawas_fetch.sv
////////////////////////////////////////
// Issues one fetch per cycle, the memory must answer next cycle
////////////////////////////////////////

`timescale 1ns/10ps

`include "tawas_cfg.svh"

module tawas_fetch (
  input  logic              clk,
  input  logic              rst_n,
  output logic              ics,
  output tawas_pkg::iaddr_t iaddr,
  output logic              instr_vld,
  output tawas_pkg::slice_t slice,
  input  logic              redirect,
  input  tawas_pkg::slice_t redirect_slice,
  input  tawas_pkg::iaddr_t redirect_addr
);
  import tawas_pkg::*;

  logic   run;
  slice_t cur;
  iaddr_t pc [`TAWAS_SLICES];

  assign ics   = run;
  assign iaddr = pc[cur];

  // Slice rotation starts in the cycle after the first edge out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run       <= 1'b0;
      cur       <= '0;
      instr_vld <= 1'b0;
      slice     <= '0;
    end else begin
      run       <= 1'b1;
      instr_vld <= run;
      slice     <= cur;
      if (run) begin
        cur <= cur + 1'b1;
      end
    end
  end

  // A redirect always belongs to the slice fetched one cycle earlier,
  // so it never collides with the increment of the current slice
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `TAWAS_SLICES; s++) begin
        pc[s] <= iaddr_t'(s * `TAWAS_SLICE_BASE);
      end
    end else begin
      if (run) begin
        pc[cur] <= pc[cur] + 1'b1;
      end
      if (redirect) begin
        pc[redirect_slice] <= redirect_addr;
      end
    end
  end

endmodule

// File: source/tawas_regbank.sv
////////////////////////////////////////
// One slice's registers, two read ports and one write port
////////////////////////////////////////

`timescale 1ns/10ps

`include "tawas_cfg.svh"

module tawas_regbank (
  input logic      clk,
  input logic      rst_n,
  tawas_rf_if.bank rf
);
  import tawas_pkg::*;

  word_t regs [`TAWAS_REGS];

  // Reads see the value stored at the last edge
  assign rf.ra = regs[rf.ra_sel];
  assign rf.rb = regs[rf.rb_sel];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `TAWAS_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (rf.we) begin
      regs[rf.wsel] <= rf.wdata;
    end
  end

endmodule

// File: source/tawas_exec.sv
////////////////////////////////////////
// Data port is driven in the decode cycle, din is due next cycle
////////////////////////////////////////

`timescale 1ns/10ps

`include "tawas_cfg.svh"

module tawas_exec (
  input  logic                clk,
  input  logic                rst_n,
  input  tawas_pkg::word_t    idata,
  input  logic                instr_vld,
  input  tawas_pkg::slice_t   slice,
  tawas_rf_if.reader          rf [`TAWAS_SLICES],
  output logic                dcs,
  output logic                dwr,
  output tawas_pkg::word_t    daddr,
  output tawas_pkg::word_t    dout,
  output logic                redirect,
  output tawas_pkg::slice_t   redirect_slice,
  output tawas_pkg::iaddr_t   redirect_addr,
  output logic                wb_vld,
  output tawas_pkg::slice_t   wb_slice,
  output tawas_pkg::reg_sel_t wb_sel,
  output logic                wb_is_load,
  output tawas_pkg::word_t    wb_data
);
  import tawas_pkg::*;

  opcode_t  op;
  reg_sel_t rc_sel;
  reg_sel_t ra_sel;
  reg_sel_t rb_sel;
  imm_t     imm;
  word_t    imm_sx;
  word_t    ra_val;
  word_t    rb_val;
  word_t    ra_bank [`TAWAS_SLICES];
  word_t    rb_bank [`TAWAS_SLICES];
  word_t    result;
  logic     writes_reg;

  assign op     = idata[OPC_MSB:OPC_LSB];
  assign rc_sel = idata[RC_MSB:RC_LSB];
  assign ra_sel = idata[RA_MSB:RA_LSB];
  assign rb_sel = idata[RB_MSB:RB_LSB];
  assign imm    = idata[IMM_MSB:IMM_LSB];
  assign imm_sx = {{16{imm[15]}}, imm};

  // Every bank sees the selects, only the executing slice's data is used
  for (genvar s = 0; s < `TAWAS_SLICES; s++) begin : g_read
    assign rf[s].ra_sel = ra_sel;
    assign rf[s].rb_sel = rb_sel;
    assign ra_bank[s]   = rf[s].ra;
    assign rb_bank[s]   = rf[s].rb;
  end

  assign ra_val = ra_bank[slice];
  assign rb_val = rb_bank[slice];

  always_comb begin
    result     = imm_sx;
    writes_reg = 1'b0;
    case (op)
      OP_LDI: writes_reg = 1'b1;
      OP_ADD: begin
        result     = ra_val + rb_val;
        writes_reg = 1'b1;
      end
      OP_SUB: begin
        result     = ra_val - rb_val;
        writes_reg = 1'b1;
      end
      OP_AND: begin
        result     = ra_val & rb_val;
        writes_reg = 1'b1;
      end
      OP_XOR: begin
        result     = ra_val ^ rb_val;
        writes_reg = 1'b1;
      end
      OP_LD:  writes_reg = 1'b1;
      OP_NOP, OP_ST, OP_BZ, OP_JMP: writes_reg = 1'b0;
      default: writes_reg = 1'b0;
    endcase
  end

  assign dcs   = instr_vld && (op == OP_LD || op == OP_ST);
  assign dwr   = instr_vld && (op == OP_ST);
  assign daddr = ra_val + imm_sx;
  assign dout  = rb_val;

  // Fetch takes the target at the end of this cycle
  assign redirect       = instr_vld && (op == OP_JMP || (op == OP_BZ && ra_val == '0));
  assign redirect_slice = slice;
  assign redirect_addr  = iaddr_t'(imm);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_vld <= 1'b0;
    end else begin
      wb_vld <= instr_vld && writes_reg;
    end
  end

  always_ff @(posedge clk) begin
    wb_slice   <= slice;
    wb_sel     <= rc_sel;
    wb_is_load <= (op == OP_LD);
    wb_data    <= result;
  end

endmodule

// File: source/tawas_writeback.sv
////////////////////////////////////////
// Results land in the bank one cycle after capture
////////////////////////////////////////

`timescale 1ns/10ps

`include "tawas_cfg.svh"

module tawas_writeback (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_vld,
  input  logic                wb_is_load,
  input  tawas_pkg::slice_t   wb_slice,
  input  tawas_pkg::reg_sel_t wb_sel,
  input  tawas_pkg::word_t    wb_data,
  input  tawas_pkg::word_t    din,
  tawas_rf_if.writer          rf [`TAWAS_SLICES]
);
  import tawas_pkg::*;

  logic [`TAWAS_SLICES-1:0] we_q;
  reg_sel_t                 wsel_q;
  word_t                    wdata_q;

  // One-hot write enable, only the owning slice's bank is written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= '0;
    end else begin
      for (int s = 0; s < `TAWAS_SLICES; s++) begin
        we_q[s] <= wb_vld && (wb_slice == slice_t'(s));
      end
    end
  end

  // din is only valid in this cycle, so the load data is captured here
  always_ff @(posedge clk) begin
    if (wb_vld) begin
      wsel_q  <= wb_sel;
      wdata_q <= wb_is_load ? din : wb_data;
    end
  end

  // The slice reads its bank again two cycles after the write lands
  for (genvar s = 0; s < `TAWAS_SLICES; s++) begin : g_write
    assign rf[s].we    = we_q[s];
    assign rf[s].wsel  = wsel_q;
    assign rf[s].wdata = wdata_q;
  end

endmodule

// File: source/tawas.sv
////////////////////////////////////////
// Four-slice barrel core, memories must answer in one cycle
// No stalls, whole-word data accesses only
////////////////////////////////////////

`timescale 1ns/10ps

`include "tawas_cfg.svh"

module tawas (
  input  logic              clk,
  input  logic              rst_n,
  output logic              ics,
  output tawas_pkg::iaddr_t iaddr,
  input  tawas_pkg::word_t  idata,
  output logic              dcs,
  output logic              dwr,
  output tawas_pkg::word_t  daddr,
  output tawas_pkg::word_t  dout,
  input  tawas_pkg::word_t  din
);
  import tawas_pkg::*;

  logic     instr_vld;
  slice_t   slice;

  logic     redirect;
  slice_t   redirect_slice;
  iaddr_t   redirect_addr;

  logic     wb_vld;
  slice_t   wb_slice;
  reg_sel_t wb_sel;
  logic     wb_is_load;
  word_t    wb_data;

  tawas_rf_if rf [`TAWAS_SLICES] ();

  tawas_fetch tawas_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .ics            (ics),
    .iaddr          (iaddr),
    .instr_vld      (instr_vld),
    .slice          (slice),
    .redirect       (redirect),
    .redirect_slice (redirect_slice),
    .redirect_addr  (redirect_addr)
  );

  for (genvar i = 0; i < `TAWAS_SLICES; i++) begin : g_bank
    tawas_regbank tawas_regbank (
      .clk   (clk),
      .rst_n (rst_n),
      .rf    (rf[i])
    );
  end

  tawas_exec tawas_exec (
    .clk            (clk),
    .rst_n          (rst_n),
    .idata          (idata),
    .instr_vld      (instr_vld),
    .slice          (slice),
    .rf             (rf),
    .dcs            (dcs),
    .dwr            (dwr),
    .daddr          (daddr),
    .dout           (dout),
    .redirect       (redirect),
    .redirect_slice (redirect_slice),
    .redirect_addr  (redirect_addr),
    .wb_vld         (wb_vld),
    .wb_slice       (wb_slice),
    .wb_sel         (wb_sel),
    .wb_is_load     (wb_is_load),
    .wb_data        (wb_data)
  );

  tawas_writeback tawas_writeback (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_vld     (wb_vld),
    .wb_is_load (wb_is_load),
    .wb_slice   (wb_slice),
    .wb_sel     (wb_sel),
    .wb_data    (wb_data),
    .din        (din),
    .rf         (rf)
  );

endmodule

// File: test/tawas_properties.sv
////////////////////////////////////////
// Bound to every tawas instance, sampled on the rising clock
////////////////////////////////////////

`timescale 1ns/10ps

module tawas_properties (
  input logic             clk,
  input logic             rst_n,
  input logic             ics,
  input logic             dcs,
  input logic             dwr,
  input tawas_pkg::word_t daddr,
  input tawas_pkg::word_t dout
);

  int fail_count = 0;

  // A write is always a data access
  assert property (@(posedge clk) disable iff (!rst_n) dwr |-> dcs)
    else begin
      $error("dwr high without dcs");
      fail_count++;
    end

  // Fetch runs every cycle once the first cycle out of reset has passed
  assert property (@(posedge clk) disable iff (!rst_n) $past(rst_n) |-> ics)
    else begin
      $error("ics low after reset");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) dcs |-> !$isunknown({daddr, dout}))
    else begin
      $error("unknown bits on daddr or dout during an access");
      fail_count++;
    end

  assert property (@(posedge clk) !rst_n |-> (!dcs && !dwr))
    else begin
      $error("data strobe high during reset");
      fail_count++;
    end

endmodule

bind tawas tawas_properties props (
  .clk   (clk),
  .rst_n (rst_n),
  .ics   (ics),
  .dcs   (dcs),
  .dwr   (dwr),
  .daddr (daddr),
  .dout  (dout)
);

// File: test/tawas_tb.sv
////////////////////////////////////////
// Memories answer one cycle after the request
// Only the low 8 address bits select a word
////////////////////////////////////////

`timescale 1ns/10ps

module tawas_tb;
  import tawas_pkg::*;

  logic   clk;
  logic   rst_n;
  logic   ics;
  iaddr_t iaddr;
  word_t  idata;
  logic   dcs;
  logic   dwr;
  word_t  daddr;
  word_t  dout;
  word_t  din;

  word_t  rom [256];
  word_t  dmem [256];
  iaddr_t ireq;
  logic   ireq_vld;
  word_t  dreq;
  logic   dreq_rd;

  // Expected stores and slice 2 fetches, matched in order per slice
  int     exp_slice [$];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  int     exp_test [$];
  int     pf_slice [$];
  word_t  pf_addr [$];

  string  names [5] = '{"reset_rotation", "alu", "load_store", "branches", "isolation"};
  int     checks [5];
  int     errs [5];
  int     stray;
  int     fetch_n;
  int     cycles;
  int     limit;
  int     prog_len [4];
  logic [31:0] rng;

  tawas dut (
    .clk   (clk),
    .rst_n (rst_n),
    .ics   (ics),
    .iaddr (iaddr),
    .idata (idata),
    .dcs   (dcs),
    .dwr   (dwr),
    .daddr (daddr),
    .dout  (dout),
    .din   (din)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int test_index(input string name);
    for (int i = 0; i < 5; i++) begin
      if (names[i] == name) return i;
    end
    return 0;
  endfunction

  task automatic check_value(input int t, input string what, input word_t exp, input word_t act);
    checks[t]++;
    if (act !== exp) begin
      errs[t]++;
      $display("ERROR %s %s: expected %h, actual %h", names[t], what, exp, act);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    int          s;
    string       tok;
    string       tname;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    fd = $fopen("test/tawas_vectors.txt", "r");
    if (fd == 0) begin
      $display("The vector file could not be opened");
      stray++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok == "#") begin
          code = $fgets(line, fd);
        end else if (tok == "I") begin
          code = $fscanf(fd, "%h %h", a, v);
          rom[a[7:0]] = v;
          prog_len[a[7:6]]++;
        end else if (tok == "D") begin
          code = $fscanf(fd, "%h %h", a, v);
          dmem[a[7:0]] = v;
        end else if (tok == "R") begin
          code = $fscanf(fd, "%h", a);
          rng = xorshift(rng);
          dmem[a[7:0]] = rng;
        end else if (tok == "E" || tok == "S") begin
          code = $fscanf(fd, "%s %d %h %h", tname, s, a, v);
          if (tok == "S") begin
            code = $fscanf(fd, "%h", b);
            v = dmem[v[7:0]] + dmem[b[7:0]];
          end
          exp_slice.push_back(s);
          exp_addr.push_back(a);
          exp_data.push_back(v);
          exp_test.push_back(test_index(tname));
        end else if (tok == "P") begin
          code = $fscanf(fd, "%s %d %h", tname, s, a);
          pf_slice.push_back(s);
          pf_addr.push_back(a);
        end else begin
          $display("Unknown record %s in the vector file", tok);
          stray++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Requests are taken on the rising edge, answers change on the falling edge
  always @(posedge clk) begin
    ireq_vld <= ics;
    ireq     <= iaddr;
    dreq_rd  <= dcs && !dwr;
    dreq     <= daddr;
    if (dcs && dwr) begin
      dmem[daddr[7:0]] <= dout;
    end
  end

  always @(negedge clk) begin
    idata <= ireq_vld ? rom[ireq[7:0]] : '0;
    if (dreq_rd) begin
      din <= dmem[dreq[7:0]];
    end
  end

  always @(posedge clk) begin
    int s;
    int idx;
    if (!rst_n) begin
      checks[0]++;
      if (ics || dcs || dwr) begin
        errs[0]++;
        $display("ics, dcs or dwr was high during reset");
      end
    end else begin
      cycles++;
      // The instruction in decode was fetched one cycle earlier
      if (dcs && dwr) begin
        s   = (fetch_n - 1) % 4;
        idx = -1;
        for (int i = 0; i < exp_slice.size(); i++) begin
          if (idx < 0 && exp_slice[i] == s) idx = i;
        end
        if (idx < 0) begin
          stray++;
          $display("Slice %0d stored %h to %h with no store expected", s, dout, daddr);
        end else begin
          check_value(exp_test[idx], "store address", exp_addr[idx], daddr);
          check_value(exp_test[idx], "store data", exp_data[idx], dout);
          exp_slice.delete(idx);
          exp_addr.delete(idx);
          exp_data.delete(idx);
          exp_test.delete(idx);
        end
      end
      if (ics) begin
        s = fetch_n % 4;
        if (fetch_n < 4) check_value(0, "first fetch", s * 64, iaddr);
        check_value(0, "fetch slice", s, iaddr[7:6]);
        if (pf_slice.size() > 0 && pf_slice[0] == s) begin
          check_value(3, "fetch address", pf_addr[0], iaddr);
          void'(pf_slice.pop_front());
          void'(pf_addr.pop_front());
        end
        fetch_n++;
      end else if (cycles > 1) begin
        errs[0]++;
        $display("ics was low in cycle %0d after reset", cycles);
      end
    end
  end

  initial begin
    int total;
    int longest;
    rst_n    = 1'b0;
    idata    = '0;
    din      = '0;
    ireq     = '0;
    ireq_vld = 1'b0;
    rng      = 32'd47002;
    for (int i = 0; i < 256; i++) begin
      rom[i]  = '0;
      dmem[i] = {16'hd0a5, 8'h00, i[7:0]};
    end
    load_vectors();
    longest = 0;
    for (int s = 0; s < 4; s++) begin
      if (prog_len[s] > longest) longest = prog_len[s];
    end
    limit = 4 * longest + 100;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while ((exp_slice.size() > 0 || pf_slice.size() > 0) && cycles < limit) begin
      @(posedge clk);
    end
    if (cycles >= limit) begin
      for (int i = 0; i < exp_slice.size(); i++) begin
        $display("The store of slice %0d to %h never arrived", exp_slice[i], exp_addr[i]);
      end
      for (int i = 0; i < pf_slice.size(); i++) begin
        $display("The fetch of slice %0d at %h never happened", pf_slice[i], pf_addr[i]);
      end
      $display("The run timed out after %0d cycles", cycles);
      $display("STATUS: FAIL");
    end else begin
      // Any store from a path that should not run would show up here
      repeat (8) @(posedge clk);
      total = stray + dut.props.fail_count;
      for (int t = 0; t < 5; t++) begin
        $display("test %s: %0d checks, %0d errors", names[t], checks[t], errs[t]);
        total += errs[t];
      end
      $display("%0d errors, %0d unexpected stores or records, %0d assertion failures",
               total, stray, dut.props.fail_count);
      if (total == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
    end
    $finish;
  end

endmodule

// File: test/tawas_vectors.txt
# I addr instr, D addr word, R addr, E test slice addr value, S test slice addr a b (sum)
# P test slice addr gives the expected fetch addresses of a slice in order, all hex
I 00 12001234
I 01 1400FFFD
I 02 26500000
I 03 38500000
I 04 4A500000
I 05 5C500000
I 06 70080010
I 07 70100011
I 08 70180012
I 09 70200013
I 0A 70280014
I 0B 70300015
I 0C 9000000C
I 40 62000020
I 41 64000021
I 42 26500000
I 43 70180022
I 44 70080023
I 45 90000045
I 80 12000005
I 81 80000083
I 82 70080030
I 83 80400086
I 84 70080032
I 85 90000087
I 86 70080033
I 87 70080035
I 88 90000088
I C0 12003333
I C1 70080043
I C2 900000C2
R 20
R 21
D 3F 00000000
E isolation 0 10 00001234
E alu 0 11 FFFFFFFD
E alu 0 12 00001231
E alu 0 13 00001237
E alu 0 14 00001234
E alu 0 15 FFFFEDC9
S load_store 1 22 20 21
S isolation 1 23 20 3F
E branches 2 32 00000005
E isolation 2 35 00000005
E isolation 3 43 00003333
P branches 2 80
P branches 2 81
P branches 2 83
P branches 2 84
P branches 2 85
P branches 2 87
P branches 2 88
P branches 2 88

// File: sim.f
+incdir+include
source/tawas_pkg.sv
source/tawas_rf_if.sv
source/tawas_fetch.sv
source/tawas_regbank.sv
source/tawas_exec.sv
source/tawas_writeback.sv
source/tawas.sv
test/tawas_properties.sv
test/tawas_tb.sv

// File: Bender.yml
package:
  name: tawas

export_include_dirs:
  - include

sources:
  - source/tawas_pkg.sv
  - source/tawas_rf_if.sv
  - source/tawas_fetch.sv
  - source/tawas_regbank.sv
  - source/tawas_exec.sv
  - source/tawas_writeback.sv
  - source/tawas.sv
  - target: test
    files:
      - test/tawas_properties.sv
      - test/tawas_tb.sv
